// File: build.f
source/rf_pkg.sv
source/rf_reset_sync.sv
source/rf_array_32x66.sv
source/rf_pg_32x66.sv
source/rf_pwr_ctrl.sv
source/rf_subsys_top.sv
sim/rf_assert.sv
sim/rf_checker.sv
sim/rf_tb.sv

// File: build.sh
#!/bin/sh
# Compile and run the register file testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module rf_tb -o rf_tb_sim
if [ $? -ne 0 ]; then
    echo "Compile step failed"
    exit 1
fi

./obj_dir/rf_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0

// File: sim/rf_assert.sv
// Ordering rules of the power sequencer outputs, bound into rf_pwr_ctrl.
// Isolation must cover every interval in which the supply is off.

module rf_assert (
     input logic             wclk
    ,input logic             arst_n
    ,input rf_pkg::pwr_ctl_t pwr_ctl
    ,input logic             pwr_done
);

    timeunit 1ns;
    timeprecision 1ps;

    // Isolation is released only with power up
    a_isol_release: assert property (@(posedge wclk) disable iff (!arst_n)
        $fell(pwr_ctl.isol_en) |-> !pwr_ctl.enable_b)
        else $error("isol_en cleared while enable_b is high");

    // Power is cut only behind isolation
    a_power_cut: assert property (@(posedge wclk) disable iff (!arst_n)
        $rose(pwr_ctl.enable_b) |-> pwr_ctl.isol_en)
        else $error("enable_b rose while isol_en is low");

    a_done_pulse: assert property (@(posedge wclk) disable iff (!arst_n)
        pwr_done |=> !pwr_done)
        else $error("pwr_done held for more than one cycle");

endmodule

bind rf_pwr_ctrl rf_assert i_rf_assert (
     .wclk     (wclk)
    ,.arst_n   (arst_n)
    ,.pwr_ctl  (pwr_ctl)
    ,.pwr_done (pwr_done)
);

// File: sim/rf_checker.sv
// Reference model of the register file contents and the power sequencer.
// Words count as written only when stored while the model is powered and open.
// Compares pwr_state, pwr_done and pwr_req_err on every wclk cycle, and rdata
// one rclk edge after each read.

module rf_checker (
     input  logic               wclk
    ,input  logic               rclk
    ,input  logic               arst_n
    ,input  rf_pkg::rf_wr_req_t wr
    ,input  rf_pkg::rf_rd_req_t rd
    ,input  rf_pkg::rf_data_t   rdata
    ,input  logic               pwr_on_req
    ,input  logic               pwr_off_req
    ,input  logic               pwr_done
    ,input  logic               pwr_req_err
    ,input  rf_pkg::pwr_state_t pwr_state
    ,output int                 errors
);

    timeunit 1ns;
    timeprecision 1ps;

    import rf_pkg::*;

    rf_data_t   model [rf_depth];
    logic       written [rf_depth];
    rf_data_t   exp_rdata;
    logic       rd_pend = 1'b0;
    logic       exp_err;
    logic       exp_done;

    // Expected sequencer state and the cycles spent waiting in it
    pwr_state_t exp_state;
    int         wait_cnt;

    // Mismatches on the power side and on the read side
    int         pwr_errors = 0;
    int         rd_errors  = 0;

    assign errors = pwr_errors + rd_errors;

    // --------------------
    // Write side model
    // --------------------
    always @(posedge wclk) begin
        if (!arst_n) begin
            exp_state = pwr_off;
            wait_cnt  = 0;
            exp_err   = 1'b0;
            exp_done  = 1'b0;
            for (int i = 0; i < rf_depth; i++) begin
                written[i] = 1'b0;
            end
        end else begin
            exp_done = 1'b0;
            // Which requests the sequencer must refuse in this state
            if (pwr_on_req && pwr_off_req) exp_err = 1'b1;
            else if (exp_state == pwr_off) exp_err = pwr_off_req;
            else if (exp_state == pwr_on) exp_err = pwr_on_req;
            else exp_err = pwr_on_req || pwr_off_req;
            // Isolation goes up here, and power is cut at the next edge
            if (exp_state == pwr_isolate) begin
                for (int i = 0; i < rf_depth; i++) begin
                    written[i] = 1'b0;
                end
            end else if (exp_state == pwr_on && wr.valid) begin
                model[wr.addr]   = wr.data;
                written[wr.addr] = 1'b1;
            end
            // Power on ends pwr_ack_delay+1 cycles after the request,
            // power off one cycle later because isolation comes first
            case (exp_state)
                pwr_off: begin
                    if (pwr_on_req && !pwr_off_req) begin
                        exp_state = pwr_wake;
                        wait_cnt  = 0;
                    end
                end
                pwr_wake: begin
                    wait_cnt++;
                    if (wait_cnt == pwr_ack_delay + 1) begin
                        exp_state = pwr_on;
                        exp_done  = 1'b1;
                    end
                end
                pwr_on: begin
                    if (pwr_off_req && !pwr_on_req) begin
                        exp_state = pwr_isolate;
                    end
                end
                pwr_isolate: begin
                    exp_state = pwr_sleep;
                    wait_cnt  = 0;
                end
                default: begin
                    // Sleep waits for the supply to be reported off
                    wait_cnt++;
                    if (wait_cnt == pwr_ack_delay + 1) begin
                        exp_state = pwr_off;
                        exp_done  = 1'b1;
                    end
                end
            endcase
        end
    end

    always @(negedge wclk) begin
        if (arst_n) begin
            if (pwr_state !== exp_state) begin
                $display("FAILED at %0t: pwr_state expected %s actual %s",
                         $time, exp_state.name(), pwr_state.name());
                pwr_errors++;
            end
            if (pwr_done !== exp_done) begin
                $display("FAILED at %0t: pwr_done expected %b actual %b",
                         $time, exp_done, pwr_done);
                pwr_errors++;
            end
            if (pwr_req_err !== exp_err) begin
                $display("FAILED at %0t: pwr_req_err expected %b actual %b",
                         $time, exp_err, pwr_req_err);
                pwr_errors++;
            end
        end
    end

    // --------------------
    // Read side model
    // --------------------
    always @(posedge rclk) begin
        rd_pend = arst_n && rd.valid;
        if (exp_state == pwr_on && written[rd.addr]) exp_rdata = model[rd.addr];
        else exp_rdata = '0;
    end

    // rdata has settled by the falling edge after the read edge
    always @(negedge rclk) begin
        if (rd_pend && rdata !== exp_rdata) begin
            $display("FAILED at %0t: rdata expected %h actual %h", $time, exp_rdata, rdata);
            rd_errors++;
        end
    end

endmodule

// File: sim/rf_tb.sv
// Testbench top for the power-gated 32x66 register file.
// wclk and rclk share a 100 ns period, rclk lags by a quarter period.
// Reads are only issued while pwr_state has been stable in pwr_on or pwr_off.

module rf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rf_pkg::*;

    logic       wclk;
    logic       rclk;
    logic       arst_n;
    rf_wr_req_t wr;
    rf_rd_req_t rd;
    rf_data_t   rdata;
    logic       pwr_on_req;
    logic       pwr_off_req;
    logic       pwr_done;
    logic       pwr_req_err;
    pwr_state_t pwr_state;

    int         chk_errors;
    int         timeouts;
    int         seed;

    // Addresses of the two most recent writes, never read back right away
    rf_addr_t   recent_addr [2];
    logic       recent_vld  [2];

    // --------------------
    // Clocks
    // --------------------
    always #50 wclk = ~wclk;

    // rclk follows wclk a quarter period later
    always @(wclk) rclk <= #25 wclk;

    rf_subsys_top i_rf_subsys_top (
         .wclk        (wclk)
        ,.rclk        (rclk)
        ,.arst_n      (arst_n)
        ,.wr          (wr)
        ,.rd          (rd)
        ,.rdata       (rdata)
        ,.pwr_on_req  (pwr_on_req)
        ,.pwr_off_req (pwr_off_req)
        ,.pwr_done    (pwr_done)
        ,.pwr_req_err (pwr_req_err)
        ,.pwr_state   (pwr_state)
    );

    rf_checker i_rf_checker (
         .wclk        (wclk)
        ,.rclk        (rclk)
        ,.arst_n      (arst_n)
        ,.wr          (wr)
        ,.rd          (rd)
        ,.rdata       (rdata)
        ,.pwr_on_req  (pwr_on_req)
        ,.pwr_off_req (pwr_off_req)
        ,.pwr_done    (pwr_done)
        ,.pwr_req_err (pwr_req_err)
        ,.pwr_state   (pwr_state)
        ,.errors      (chk_errors)
    );

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    // Waits for the end of a power sequence, sampled away from the clock edge
    task automatic wait_done(input int limit);
        int n;
        n = 0;
        @(negedge wclk);
        while (!pwr_done && n < limit) begin
            @(negedge wclk);
            n++;
        end
        if (!pwr_done) begin
            $display("Timeout at %0t: no pwr_done within %0d cycles", $time, limit);
            timeouts++;
        end
        @(posedge wclk);
    endtask

    // One-cycle request strobe, then a wait for the sequence to finish
    task automatic power_request(input logic on, input logic bad_in_seq);
        int n;
        if (on) pwr_on_req <= 1'b1;
        else pwr_off_req <= 1'b1;
        @(posedge wclk);
        pwr_on_req  <= 1'b0;
        pwr_off_req <= 1'b0;
        // A second request during the sequence must be refused
        if (bad_in_seq) begin
            @(posedge wclk);
            pwr_on_req <= 1'b1;
            @(posedge wclk);
            pwr_on_req <= 1'b0;
        end
        wait_done(20);
        // Let the state settle before any read
        for (n = 0; n < 3; n++) begin
            @(posedge wclk);
        end
    endtask

    // Random writes on wclk and reads on rclk
    task automatic traffic(input int cycles);
        logic [31:0] r;
        logic [95:0] d;
        rf_addr_t    ra;
        for (int i = 0; i < cycles; i++) begin
            @(posedge wclk);
            r = rand32();
            recent_addr[1] = recent_addr[0];
            recent_vld[1]  = recent_vld[0];
            recent_vld[0]  = 1'b0;
            if (r[1:0] != 2'b00) begin
                d = {rand32(), rand32(), rand32()};
                wr <= '{valid: 1'b1, addr: r[8:4], data: d[rf_width-1:0]};
                recent_addr[0] = r[8:4];
                recent_vld[0]  = 1'b1;
            end else begin
                wr.valid <= 1'b0;
            end
            @(posedge rclk);
            r  = rand32();
            ra = r[8:4];
            if (r[2] && !(recent_vld[0] && recent_addr[0] == ra)
                    && !(recent_vld[1] && recent_addr[1] == ra)) begin
                rd <= '{valid: 1'b1, addr: ra};
            end else begin
                rd.valid <= 1'b0;
            end
        end
        @(posedge wclk);
        wr.valid <= 1'b0;
        @(posedge rclk);
        rd.valid <= 1'b0;
        recent_vld[0] = 1'b0;
        recent_vld[1] = 1'b0;
    endtask

    initial begin
        seed        = 32'hcc8c;
        wclk        = 1'b0;
        rclk        = 1'b0;
        arst_n      = 1'b0;
        wr          = '0;
        rd          = '0;
        pwr_on_req  = 1'b0;
        pwr_off_req = 1'b0;
        timeouts    = 0;
        recent_vld[0] = 1'b0;
        recent_vld[1] = 1'b0;
        repeat (3) @(posedge wclk);
        arst_n <= 1'b1;
        // The acknowledge chain fills with enable_b high
        repeat (6) @(posedge wclk);

        // Reads while off return zero
        traffic(20);
        power_request(1'b1, 1'b0);
        traffic(200);
        // Power on while on is refused
        pwr_on_req <= 1'b1;
        @(posedge wclk);
        pwr_on_req <= 1'b0;
        repeat (3) @(posedge wclk);
        power_request(1'b0, 1'b1);
        // Writes while off are dropped
        traffic(60);
        power_request(1'b1, 1'b1);
        traffic(200);
        power_request(1'b0, 1'b0);
        power_request(1'b1, 1'b0);
        traffic(150);
        repeat (3) @(posedge wclk);

        $display("Errors: checker %0d, timeouts %0d", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: source/rf_array_32x66.sv
// Behavioral stand-in for the 32x66 two-port memory macro.
// Writes on wclk, reads on rclk, read data is registered and holds between reads.
// Contents read as zero after power is removed and stay zero until rewritten.
// pwr_ack_b has no reset; it is valid pwr_ack_delay wclk cycles after enable_b
// has been held high, which the sequencer does while in reset.

module rf_array_32x66 (
     input  logic               wclk
    ,input  rf_pkg::rf_wr_req_t wr

    ,input  logic               rclk
    ,input  logic               rst_n_r
    ,input  rf_pkg::rf_rd_req_t rd
    ,output rf_pkg::rf_data_t   rdata

    ,input  rf_pkg::pwr_ctl_t   pwr_ctl
    ,input  logic               isol_r
    ,output logic               pwr_ack_b
);

    import rf_pkg::*;

    // Storage of the macro
    rf_data_t mem [rf_depth];

    // Models the delay of the power switches settling after enable_b changes
    logic [pwr_ack_delay-1:0] ack_sr;

    // --------------------
    // Power acknowledge
    // --------------------
    // enable_b enters at bit 0 and reaches the output after pwr_ack_delay edges
    always_ff @(posedge wclk) begin
        ack_sr <= {ack_sr[pwr_ack_delay-2:0], pwr_ctl.enable_b};
    end

    // Acknowledge is the last stage of the chain
    assign pwr_ack_b = ack_sr[pwr_ack_delay-1];

    // --------------------
    // Write port
    // --------------------
    // While enable_b is high the array has no supply, so every word is held at zero.
    // This also covers the rising edge of enable_b, where the old contents are lost
    always_ff @(posedge wclk) begin
        if (pwr_ctl.enable_b) begin
            for (int i = 0; i < rf_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.valid && !pwr_ctl.isol_en) begin
            // Only a powered, de-isolated array accepts data
            mem[wr.addr] <= wr.data;
        end
    end

    // --------------------
    // Read port
    // --------------------
    // One rclk edge from request to data.
    // When the isolation status seen in rclk is set, the outputs are clamped to zero
    always_ff @(posedge rclk or negedge rst_n_r) begin
        if (!rst_n_r) begin
            rdata <= '0;
        end else if (rd.valid) begin
            if (isol_r) begin
                // Isolated macro drives its outputs low
                rdata <= '0;
            end else begin
                rdata <= mem[rd.addr];
            end
        end
    end

    // No read request: rdata keeps the last word read

endmodule

// File: source/rf_pg_32x66.sv
// Wrapper around the 32x66 array in the role of the power-gated macro wrapper.
// Makes the read-domain reset and brings the isolation status into rclk.
// The isolation status reaches rclk two rclk edges late, so reads issued right
// after a power change may still see the previous state.
// pwr_ctl and pwr_ack_b are in the wclk domain.

module rf_pg_32x66 (
     input  logic               wclk
    ,input  logic               rclk
    ,input  logic               arst_n

    ,input  rf_pkg::rf_wr_req_t wr
    ,input  rf_pkg::rf_rd_req_t rd
    ,output rf_pkg::rf_data_t   rdata

    // Power interface to the sequencer
    ,input  rf_pkg::pwr_ctl_t   pwr_ctl
    ,output logic               pwr_ack_b
);

    // Read-domain reset, released on rclk
    logic rst_n_r;

    // Isolation status as seen by the read port
    logic isol_r;

    // --------------------
    // Read-side synchronizers
    // --------------------
    // d tied high gives a reset that asserts at once and releases on rclk
    rf_reset_sync i_rst_sync_r (
         .clk_in (rclk)
        ,.arst_n (arst_n)
        ,.d      (1'b1)
        ,.q      (rst_n_r)
    );

    // Carries isol_en across; it is a slow level held for many cycles
    rf_reset_sync i_isol_sync_r (
         .clk_in (rclk)
        ,.arst_n (arst_n)
        ,.d      (pwr_ctl.isol_en)
        ,.q      (isol_r)
    );

    // --------------------
    // Memory
    // --------------------
    rf_array_32x66 i_rf (
         .wclk      (wclk)
        ,.wr        (wr)
        ,.rclk      (rclk)
        ,.rst_n_r   (rst_n_r)
        ,.rd        (rd)
        ,.rdata     (rdata)
        ,.pwr_ctl   (pwr_ctl)
        ,.isol_r    (isol_r)
        ,.pwr_ack_b (pwr_ack_b)
    );

endmodule

// File: source/rf_pkg.sv
// Shared types and constants for the 32x66 power-gated register file.
// The array size is fixed, so the dimensions live here and not on modules.
// pwr_ack_delay must be at least 2 because the acknowledge is a shift chain.

package rf_pkg;

    // --------------------
    // Array dimensions
    // --------------------
    localparam int rf_depth = 32;
    localparam int rf_width = 66;

    // Address and data words as seen on both ports
    typedef logic [$clog2(rf_depth)-1:0] rf_addr_t;
    typedef logic [rf_width-1:0]         rf_data_t;

    // --------------------
    // Power timing
    // --------------------
    // Cycles of wclk from a change of enable_b to the matching change of the acknowledge
    localparam int pwr_ack_delay = 4;

    // Sequencer states, also reported on the top-level status port
    typedef enum logic [2:0] {
        pwr_off,
        pwr_wake,
        pwr_on,
        pwr_isolate,
        pwr_sleep
    } pwr_state_t;

    // --------------------
    // Grouped signals
    // --------------------
    // Write request on wclk, one cycle per word
    typedef struct packed {
        logic     valid;
        rf_addr_t addr;
        rf_data_t data;
    } rf_wr_req_t;

    // Read request on rclk, data follows on the next rclk edge
    typedef struct packed {
        logic     valid;
        rf_addr_t addr;
    } rf_rd_req_t;

    // Power controls from the sequencer to the wrapper, both active high means off
    typedef struct packed {
        logic enable_b;
        logic isol_en;
    } pwr_ctl_t;

endpackage

// File: source/rf_pwr_ctrl.sv
// Power sequencer for the register file, in the wclk domain.
// Power on: clear enable_b, wait for the acknowledge, then release isolation.
// Power off: isolate first, then set enable_b and wait for the acknowledge.
// Requests are single-cycle strobes with no back-pressure. A request that does
// not apply in the current state is dropped and flagged on pwr_req_err.

module rf_pwr_ctrl (
     input  logic               wclk
    ,input  logic               arst_n

    ,input  logic               pwr_on_req
    ,input  logic               pwr_off_req
    ,input  logic               pwr_ack_b

    ,output rf_pkg::pwr_ctl_t   pwr_ctl
    ,output rf_pkg::pwr_state_t pwr_state
    ,output logic               pwr_done
    ,output logic               pwr_req_err
);

    import rf_pkg::*;

    // Both strobes in one cycle, neither can be honored
    logic req_both;

    // Request that does not apply in the current state
    logic req_bad;

    assign req_both = pwr_on_req && pwr_off_req;

    // --------------------
    // Request check
    // --------------------
    always_comb begin
        case (pwr_state)
            // Only power on applies when off
            pwr_off: req_bad = pwr_off_req;
            // Only power off applies when on
            pwr_on:  req_bad = pwr_on_req;
            // A sequence is running, nothing applies
            default: req_bad = pwr_on_req || pwr_off_req;
        endcase
        if (req_both) begin
            req_bad = 1'b1;
        end
    end

    // --------------------
    // Sequencer FSM
    // --------------------
    // Outputs are registered so the array sees clean levels
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_state        <= pwr_off;
            pwr_ctl.enable_b <= 1'b1;
            pwr_ctl.isol_en  <= 1'b1;
            pwr_done         <= 1'b0;
            pwr_req_err      <= 1'b0;
        end else begin
            // Both flags are single-cycle pulses
            pwr_done    <= 1'b0;
            pwr_req_err <= req_bad;

            case (pwr_state)
                pwr_off: begin
                    // Supply comes up first, isolation stays on
                    if (pwr_on_req && !req_both) begin
                        pwr_ctl.enable_b <= 1'b0;
                        pwr_state        <= pwr_wake;
                    end
                end
                pwr_wake: begin
                    // Wait for the switches to settle before releasing isolation
                    if (!pwr_ack_b) begin
                        pwr_ctl.isol_en <= 1'b0;
                        pwr_state       <= pwr_on;
                        pwr_done        <= 1'b1;
                    end
                end
                pwr_on: begin
                    // Clamp the outputs before the supply goes away
                    if (pwr_off_req && !req_both) begin
                        pwr_ctl.isol_en <= 1'b1;
                        pwr_state       <= pwr_isolate;
                    end
                end
                pwr_isolate: begin
                    // Isolation has been up for one cycle, now cut power
                    pwr_ctl.enable_b <= 1'b1;
                    pwr_state        <= pwr_sleep;
                end
                pwr_sleep: begin
                    // Off is reported once the array confirms it
                    if (pwr_ack_b) begin
                        pwr_state <= pwr_off;
                        pwr_done  <= 1'b1;
                    end
                end
                default: begin
                    // Unused encodings fall back to the safe off state
                    pwr_ctl.enable_b <= 1'b1;
                    pwr_ctl.isol_en  <= 1'b1;
                    pwr_state        <= pwr_off;
                end
            endcase
        end
    end

endmodule

// File: source/rf_reset_sync.sv
// Two-flop synchronizer into the clk_in domain, cleared by arst_n.
// Tied high on d it releases a reset synchronously to clk_in.
// Only safe for single-bit, slowly changing levels.

module rf_reset_sync (
     input  logic clk_in
    ,input  logic arst_n
    ,input  logic d
    ,output logic q
);

    // First stage may go metastable, second stage is the one used
    logic meta;

    // --------------------
    // Synchronizer chain
    // --------------------
    // Assertion of arst_n is immediate, the release takes two clk_in edges
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            meta <= 1'b0;
            q    <= 1'b0;
        end else begin
            // Sample the asynchronous level
            meta <= d;
            // Hand it on one edge later, now settled
            q    <= meta;
        end
    end

endmodule

// File: source/rf_subsys_top.sv
// Top level of the power-gated 32x66 register file.
// Write side and power requests are on wclk, reads are on rclk.
// Power on takes pwr_ack_delay+1 wclk cycles, power off pwr_ack_delay+2.
// Data in the array is lost on every power off.

module rf_subsys_top (
     input  logic               wclk
    ,input  logic               rclk
    ,input  logic               arst_n

    ,input  rf_pkg::rf_wr_req_t wr
    ,input  rf_pkg::rf_rd_req_t rd
    ,output rf_pkg::rf_data_t   rdata

    ,input  logic               pwr_on_req
    ,input  logic               pwr_off_req
    ,output logic               pwr_done
    ,output logic               pwr_req_err
    ,output rf_pkg::pwr_state_t pwr_state
);

    import rf_pkg::*;

    // Enable and isolation from the sequencer
    pwr_ctl_t pwr_ctl;

    // Acknowledge from the array back to the sequencer
    logic     pwr_ack_b;

    // --------------------
    // Power sequencer
    // --------------------
    rf_pwr_ctrl i_rf_pwr_ctrl (
         .wclk        (wclk)
        ,.arst_n      (arst_n)
        ,.pwr_on_req  (pwr_on_req)
        ,.pwr_off_req (pwr_off_req)
        ,.pwr_ack_b   (pwr_ack_b)
        ,.pwr_ctl     (pwr_ctl)
        ,.pwr_state   (pwr_state)
        ,.pwr_done    (pwr_done)
        ,.pwr_req_err (pwr_req_err)
    );

    // --------------------
    // Memory wrapper
    // --------------------
    rf_pg_32x66 i_rf_pg_32x66 (
         .wclk      (wclk)
        ,.rclk      (rclk)
        ,.arst_n    (arst_n)
        ,.wr        (wr)
        ,.rd        (rd)
        ,.rdata     (rdata)
        ,.pwr_ctl   (pwr_ctl)
        ,.pwr_ack_b (pwr_ack_b)
    );

endmodule
